// ==== all.f ====
+incdir+test
rtl/riscv_isa_pkg.sv
rtl/riscv_pipe_pkg.sv
rtl/riscv_fstage.sv
rtl/riscv_regfile.sv
rtl/riscv_dstage.sv
rtl/riscv_estage.sv
rtl/riscv_hazard.sv
rtl/riscv_core.sv
test/tb_riscv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIMFLAGS  ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIMFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_riscv_ref.svh ====
`ifndef TB_RISCV_REF_SVH
`define TB_RISCV_REF_SVH

localparam int PROG_LEN = 64;

// major opcodes of the kept instructions
localparam logic [6:0] OPC_R = 7'h33;
localparam logic [6:0] OPC_I = 7'h13;
localparam logic [6:0] OPC_U = 7'h37;
localparam logic [6:0] OPC_B = 7'h63;

logic [31:0] lfsr_q = 32'h0ce5a62e;
logic [31:0] prog [PROG_LEN];
logic [63:0] iss_pc;
logic [63:0] iss_regs [32];  // architectural state, x0 never written

// x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
  logic fb;
  fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
  lfsr_q = {lfsr_q[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int k = 0; k < n; k++) begin
    r = {r[30:0], lfsr_bit()};
  end
  return r;
endfunction

function automatic void build_program();
  logic [31:0] r, u;
  logic [4:0]  rd, rs1, rs2;
  logic [2:0]  f3;
  logic [11:0] imm;
  logic [12:0] ofs;
  int          skip;
  for (int i = 0; i < PROG_LEN - 1; i++) begin
    r   = rand_bits(32);
    rd  = {2'b00, r[2:0]};  // x0..x7 only
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    f3  = r[11:9];
    case (r[14:12])
      3'd6: begin
        u       = rand_bits(20);
        prog[i] = {u[19:0], rd, OPC_U};
      end
      3'd7: begin
        skip = int'(r[19:18]) + 1;
        if (i + skip > PROG_LEN - 1) skip = PROG_LEN - 1 - i;  // stay inside the program
        ofs     = 13'(skip * 4);
        f3      = {r[17], 1'b0, r[16]};  // beq, bne, blt, bge
        prog[i] = {ofs[12], ofs[10:5], rs2, rs1, f3, ofs[4:1], ofs[11], OPC_B};
      end
      3'd3, 3'd4, 3'd5: begin
        if (f3 == 3'b001) imm = {6'b0, r[25:20]};
        else if (f3 == 3'b101) imm = {1'b0, r[15], 4'b0, r[25:20]};  // srli / srai
        else imm = r[31:20];
        prog[i] = {imm, rs1, f3, rd, OPC_I};
      end
      default: begin
        prog[i] = {1'b0, r[15] & (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd, OPC_R};
      end
    endcase
  end
  prog[PROG_LEN-1] = {25'b0, OPC_B};  // beq x0,x0,0
endfunction

function automatic void iss_reset();
  iss_pc = riscv_pipe_pkg::RESET_PC;
  for (int k = 0; k < 32; k++) begin
    iss_regs[k] = '0;
  end
endfunction

// executes one instruction and reports what it retires
function automatic void iss_step(output logic [63:0] ret_pc, output logic ret_we,
                                 output logic [4:0] ret_rd, output logic [63:0] ret_data);
  logic [63:0] ofs, a, b, next;
  logic [31:0] inst;
  logic        taken;
  ofs      = iss_pc - riscv_pipe_pkg::RESET_PC;
  inst     = prog[ofs[7:2]];
  ret_pc   = iss_pc;
  ret_rd   = inst[11:7];
  ret_we   = 1'b1;
  ret_data = '0;
  a        = iss_regs[inst[19:15]];
  b        = iss_regs[inst[24:20]];
  next     = iss_pc + 64'd4;
  case (inst[6:0])
    OPC_R, OPC_I: begin
      if (inst[6:0] == OPC_I) b = {{52{inst[31]}}, inst[31:20]};
      case (inst[14:12])
        3'b000:  ret_data = (inst[6:0] == OPC_R && inst[30]) ? a - b : a + b;
        3'b001:  ret_data = a << b[5:0];
        3'b010:  ret_data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'b011:  ret_data = (a < b) ? 64'd1 : 64'd0;
        3'b100:  ret_data = a ^ b;
        3'b101:  ret_data = inst[30] ? $unsigned($signed(a) >>> b[5:0]) : a >> b[5:0];
        3'b110:  ret_data = a | b;
        default: ret_data = a & b;
      endcase
    end
    OPC_U: ret_data = {{32{inst[31]}}, inst[31:12], 12'b0};
    default: begin  // branches never write
      ret_we = 1'b0;
      case (inst[14:12])
        3'b000:  taken = (a == b);
        3'b001:  taken = (a != b);
        3'b100:  taken = $signed(a) < $signed(b);
        default: taken = $signed(a) >= $signed(b);
      endcase
      if (taken) next = iss_pc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    end
  endcase
  if (ret_we && ret_rd != 5'd0) iss_regs[ret_rd] = ret_data;
  iss_pc = next;
endfunction

`endif

// ==== test/tb_riscv_core.sv ====
`timescale 1ns/1ps

module tb_riscv_core;

  localparam logic [63:0] LOOP_PC = riscv_pipe_pkg::RESET_PC + 64'd252;  // last program word
  localparam int RETIRE_TIMEOUT = 50;

  logic        riscv_clk;
  logic        rst_n;
  logic [31:0] imem_data;
  logic        imem_valid;
  logic [63:0] fetch_pc;
  logic        wb_valid;
  logic [63:0] wb_pc;
  logic        wb_we;
  logic [4:0]  wb_rd;
  logic [63:0] wb_data;
  int          accepted = 0;

  `include "tb_riscv_ref.svh"

  riscv_core i_riscv_core (
    .i_riscv_clk  (riscv_clk),
    .i_rst_n      (rst_n),
    .i_inst       (imem_data),
    .i_inst_valid (imem_valid),
    .o_pc         (fetch_pc),
    .o_wb_valid   (wb_valid),
    .o_wb_pc      (wb_pc),
    .o_wb_we      (wb_we),
    .o_wb_rd      (wb_rd),
    .o_wb_data    (wb_data)
  );

  initial begin
    riscv_clk = 1'b0;
    forever #2 riscv_clk = ~riscv_clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: time %0t %s got 0x%h expected 0x%h", $time, name, got, exp));
    end
  endtask

  // wrong-path fetches outside the program read a nop
  function automatic logic [31:0] imem_read(input logic [63:0] addr);
    logic [63:0] ofs;
    ofs = addr - riscv_pipe_pkg::RESET_PC;
    if (addr < riscv_pipe_pkg::RESET_PC || ofs >= 64'(PROG_LEN * 4)) begin
      return 32'h0000_0013;
    end
    return prog[ofs[7:2]];
  endfunction

  task automatic wait_retirement();
    int waited;
    waited = 0;
    @(negedge riscv_clk);
    while (wb_valid !== 1'b1) begin
      waited++;
      if (waited > RETIRE_TIMEOUT) begin
        abort_run("no instruction retired within 50 cycles");
      end
      @(negedge riscv_clk);
    end
  endtask

  always @(posedge riscv_clk) begin
    if (rst_n && imem_valid) accepted <= accepted + 1;
  end

  // reset followed by the instruction memory answering o_pc
  initial begin
    logic [31:0] r;
    rst_n      = 1'b0;
    imem_valid = 1'b0;
    imem_data  = 32'h0000_0013;
    build_program();
    iss_reset();
    repeat (4) begin
      @(posedge riscv_clk);
      #0.5;
      compare_value("o_pc", fetch_pc, riscv_pipe_pkg::RESET_PC);
      compare_value("o_wb_valid", 64'(wb_valid), 64'd0);
      compare_value("o_wb_we", 64'(wb_we), 64'd0);
    end
    rst_n = 1'b1;
    forever begin
      r          = rand_bits(2);
      imem_valid = (r[1:0] != 2'b11);  // low about a quarter of the time
      imem_data  = imem_read(fetch_pc);
      @(posedge riscv_clk);
      #0.5;
    end
  end

  // retirement stream against the reference model
  initial begin
    logic [63:0] exp_pc, exp_data;
    logic        exp_we;
    logic [4:0]  exp_rd;
    int          retired;
    bit          done;
    retired = 0;
    done    = 1'b0;
    while (!done) begin
      wait_retirement();
      if (accepted == 0) begin
        abort_run("an instruction retired before any instruction was accepted");
      end
      iss_step(exp_pc, exp_we, exp_rd, exp_data);
      compare_value("o_wb_pc", wb_pc, exp_pc);
      compare_value("o_wb_we", 64'(wb_we), 64'(exp_we));
      if (exp_we) begin
        compare_value("o_wb_rd", 64'(wb_rd), 64'(exp_rd));
        compare_value("o_wb_data", wb_data, exp_data);
      end
      retired++;
      if (exp_pc == LOOP_PC) begin
        done = 1'b1;
      end
    end
    $display("retired %0d instructions", retired);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== rtl/riscv_core.sv ====
`timescale 1ns/1ps

module riscv_core (
  input  logic                              i_riscv_clk,
  input  logic                              i_rst_n,
  input  logic [riscv_isa_pkg::INST_W-1:0]  i_inst,
  input  logic                              i_inst_valid,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_pc,
  output logic                              o_wb_valid,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_wb_pc,
  output logic                              o_wb_we,
  output logic [riscv_pipe_pkg::REG_AW-1:0] o_wb_rd,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_wb_data
);

  // fetch/decode
  logic                              fd_valid;
  logic [riscv_pipe_pkg::XLEN-1:0]   fd_pc;
  logic [riscv_isa_pkg::INST_W-1:0]  fd_inst;

  // regfile read side
  logic [riscv_pipe_pkg::REG_AW-1:0] rs1_addr, rs2_addr;
  logic [riscv_pipe_pkg::XLEN-1:0]   rs1_data, rs2_data;

  // decode/execute
  logic                              de_valid, de_we, de_use_imm;
  logic [riscv_pipe_pkg::XLEN-1:0]   de_pc, de_rs1_data, de_rs2_data, de_imm;
  logic [riscv_pipe_pkg::REG_AW-1:0] de_rs1_addr, de_rs2_addr, de_rd;
  riscv_isa_pkg::alu_op_e            de_alu_op;
  riscv_isa_pkg::br_cond_e           de_br_cond;

  // control
  logic                              br_taken, flush;
  logic [riscv_pipe_pkg::XLEN-1:0]   br_target;
  riscv_pipe_pkg::fwd_sel_e          fwd_a, fwd_b;

  riscv_fstage u_riscv_fstage (
    .i_riscv_clk  (i_riscv_clk),
    .i_rst_n      (i_rst_n),
    .i_inst       (i_inst),
    .i_inst_valid (i_inst_valid),
    .i_flush      (flush),
    .i_br_target  (br_target),
    .o_pc         (o_pc),
    .o_fd_valid   (fd_valid),
    .o_fd_pc      (fd_pc),
    .o_fd_inst    (fd_inst)
  );

  riscv_dstage u_riscv_dstage (
    .i_riscv_clk   (i_riscv_clk),
    .i_rst_n       (i_rst_n),
    .i_flush       (flush),
    .i_fd_valid    (fd_valid),
    .i_fd_pc       (fd_pc),
    .i_fd_inst     (fd_inst),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .o_rs1_addr    (rs1_addr),
    .o_rs2_addr    (rs2_addr),
    .o_de_valid    (de_valid),
    .o_de_pc       (de_pc),
    .o_de_rs1_addr (de_rs1_addr),
    .o_de_rs2_addr (de_rs2_addr),
    .o_de_rs1_data (de_rs1_data),
    .o_de_rs2_data (de_rs2_data),
    .o_de_imm      (de_imm),
    .o_de_rd       (de_rd),
    .o_de_we       (de_we),
    .o_de_alu_op   (de_alu_op),
    .o_de_br_cond  (de_br_cond),
    .o_de_use_imm  (de_use_imm)
  );

  // write port fed straight from the writeback register
  riscv_regfile u_riscv_regfile (
    .i_riscv_clk (i_riscv_clk),
    .i_rst_n     (i_rst_n),
    .i_rs1_addr  (rs1_addr),
    .i_rs2_addr  (rs2_addr),
    .i_we        (o_wb_we),
    .i_rd_addr   (o_wb_rd),
    .i_rd_data   (o_wb_data),
    .o_rs1_data  (rs1_data),
    .o_rs2_data  (rs2_data)
  );

  riscv_estage u_riscv_estage (
    .i_riscv_clk   (i_riscv_clk),
    .i_rst_n       (i_rst_n),
    .i_de_valid    (de_valid),
    .i_de_pc       (de_pc),
    .i_de_rs1_data (de_rs1_data),
    .i_de_rs2_data (de_rs2_data),
    .i_de_imm      (de_imm),
    .i_de_rd       (de_rd),
    .i_de_we       (de_we),
    .i_de_alu_op   (de_alu_op),
    .i_de_br_cond  (de_br_cond),
    .i_de_use_imm  (de_use_imm),
    .i_fwd_a       (fwd_a),
    .i_fwd_b       (fwd_b),
    .o_br_taken    (br_taken),
    .o_br_target   (br_target),
    .o_wb_valid    (o_wb_valid),
    .o_wb_pc       (o_wb_pc),
    .o_wb_we       (o_wb_we),
    .o_wb_rd       (o_wb_rd),
    .o_wb_data     (o_wb_data)
  );

  riscv_hazard u_riscv_hazard (
    .i_de_valid    (de_valid),
    .i_de_rs1_addr (de_rs1_addr),
    .i_de_rs2_addr (de_rs2_addr),
    .i_wb_valid    (o_wb_valid),
    .i_wb_we       (o_wb_we),
    .i_wb_rd       (o_wb_rd),
    .i_br_taken    (br_taken),
    .o_fwd_a       (fwd_a),
    .o_fwd_b       (fwd_b),
    .o_flush       (flush)
  );

endmodule

// ==== rtl/riscv_hazard.sv ====
`timescale 1ns/1ps

module riscv_hazard (
  input  logic                              i_de_valid,
  input  logic [riscv_pipe_pkg::REG_AW-1:0] i_de_rs1_addr,
  input  logic [riscv_pipe_pkg::REG_AW-1:0] i_de_rs2_addr,
  input  logic                              i_wb_valid,
  input  logic                              i_wb_we,
  input  logic [riscv_pipe_pkg::REG_AW-1:0] i_wb_rd,
  input  logic                              i_br_taken,
  output riscv_pipe_pkg::fwd_sel_e          o_fwd_a,
  output riscv_pipe_pkg::fwd_sel_e          o_fwd_b,
  output logic                              o_flush
);

  logic wb_writes;  // writeback holds a live nonzero destination

  assign wb_writes = i_wb_valid & i_wb_we & (i_wb_rd != '0);

  assign o_fwd_a = (wb_writes && (i_wb_rd == i_de_rs1_addr)) ? riscv_pipe_pkg::FWD_WB
                                                             : riscv_pipe_pkg::FWD_NONE;
  assign o_fwd_b = (wb_writes && (i_wb_rd == i_de_rs2_addr)) ? riscv_pipe_pkg::FWD_WB
                                                             : riscv_pipe_pkg::FWD_NONE;

  // kills fetch/decode and decode/execute at the next edge
  assign o_flush = i_de_valid & i_br_taken;

endmodule

// ==== rtl/riscv_estage.sv ====
`timescale 1ns/1ps

module riscv_estage (
  input  logic                              i_riscv_clk,
  input  logic                              i_rst_n,
  input  logic                              i_de_valid,
  input  logic [riscv_pipe_pkg::XLEN-1:0]   i_de_pc,
  input  logic [riscv_pipe_pkg::XLEN-1:0]   i_de_rs1_data,
  input  logic [riscv_pipe_pkg::XLEN-1:0]   i_de_rs2_data,
  input  logic [riscv_pipe_pkg::XLEN-1:0]   i_de_imm,
  input  logic [riscv_pipe_pkg::REG_AW-1:0] i_de_rd,
  input  logic                              i_de_we,
  input  riscv_isa_pkg::alu_op_e            i_de_alu_op,
  input  riscv_isa_pkg::br_cond_e           i_de_br_cond,
  input  logic                              i_de_use_imm,
  input  riscv_pipe_pkg::fwd_sel_e          i_fwd_a,
  input  riscv_pipe_pkg::fwd_sel_e          i_fwd_b,
  output logic                              o_br_taken,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_br_target,
  output logic                              o_wb_valid,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_wb_pc,
  output logic                              o_wb_we,
  output logic [riscv_pipe_pkg::REG_AW-1:0] o_wb_rd,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_wb_data
);

  logic [riscv_pipe_pkg::XLEN-1:0]         src_a, src_b, op_b, alu_res;
  logic [$clog2(riscv_pipe_pkg::XLEN)-1:0] shamt;

  // one-instruction distance comes from the writeback register
  assign src_a = (i_fwd_a == riscv_pipe_pkg::FWD_WB) ? o_wb_data : i_de_rs1_data;
  assign src_b = (i_fwd_b == riscv_pipe_pkg::FWD_WB) ? o_wb_data : i_de_rs2_data;
  assign op_b  = i_de_use_imm ? i_de_imm : src_b;
  assign shamt = op_b[$clog2(riscv_pipe_pkg::XLEN)-1:0];

  always_comb begin
    case (i_de_alu_op)
      riscv_isa_pkg::ALU_SUB:    alu_res = src_a - op_b;
      riscv_isa_pkg::ALU_AND:    alu_res = src_a & op_b;
      riscv_isa_pkg::ALU_OR:     alu_res = src_a | op_b;
      riscv_isa_pkg::ALU_XOR:    alu_res = src_a ^ op_b;
      riscv_isa_pkg::ALU_SLL:    alu_res = src_a << shamt;
      riscv_isa_pkg::ALU_SRL:    alu_res = src_a >> shamt;
      riscv_isa_pkg::ALU_SRA:    alu_res = $signed(src_a) >>> shamt;
      riscv_isa_pkg::ALU_SLT:    alu_res = {63'b0, $signed(src_a) < $signed(op_b)};
      riscv_isa_pkg::ALU_SLTU:   alu_res = {63'b0, src_a < op_b};
      riscv_isa_pkg::ALU_PASS_B: alu_res = op_b;
      default:                   alu_res = src_a + op_b;
    endcase
  end

  // branch compares rs1 with rs2, never the immediate
  always_comb begin
    case (i_de_br_cond)
      riscv_isa_pkg::BR_EQ: o_br_taken = (src_a == src_b);
      riscv_isa_pkg::BR_NE: o_br_taken = (src_a != src_b);
      riscv_isa_pkg::BR_LT: o_br_taken = $signed(src_a) < $signed(src_b);
      riscv_isa_pkg::BR_GE: o_br_taken = $signed(src_a) >= $signed(src_b);
      default:              o_br_taken = 1'b0;
    endcase
  end

  assign o_br_target = i_de_pc + i_de_imm;

  always_ff @(posedge i_riscv_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
      o_wb_we    <= 1'b0;
    end else begin
      o_wb_valid <= i_de_valid;
      o_wb_we    <= i_de_valid & i_de_we;  // low for branches
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    o_wb_pc   <= i_de_pc;
    o_wb_rd   <= i_de_rd;
    o_wb_data <= alu_res;
  end

endmodule

// ==== rtl/riscv_dstage.sv ====
`timescale 1ns/1ps

module riscv_dstage (
  input  logic                              i_riscv_clk,
  input  logic                              i_rst_n,
  input  logic                              i_flush,
  input  logic                              i_fd_valid,
  input  logic [riscv_pipe_pkg::XLEN-1:0]   i_fd_pc,
  input  logic [riscv_isa_pkg::INST_W-1:0]  i_fd_inst,
  input  logic [riscv_pipe_pkg::XLEN-1:0]   i_rs1_data,
  input  logic [riscv_pipe_pkg::XLEN-1:0]   i_rs2_data,
  output logic [riscv_pipe_pkg::REG_AW-1:0] o_rs1_addr,  // to regfile
  output logic [riscv_pipe_pkg::REG_AW-1:0] o_rs2_addr,
  output logic                              o_de_valid,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_de_pc,
  output logic [riscv_pipe_pkg::REG_AW-1:0] o_de_rs1_addr,
  output logic [riscv_pipe_pkg::REG_AW-1:0] o_de_rs2_addr,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_de_rs1_data,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_de_rs2_data,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_de_imm,
  output logic [riscv_pipe_pkg::REG_AW-1:0] o_de_rd,
  output logic                              o_de_we,
  output riscv_isa_pkg::alu_op_e            o_de_alu_op,
  output riscv_isa_pkg::br_cond_e           o_de_br_cond,
  output logic                              o_de_use_imm
);

  logic [riscv_isa_pkg::INST_W-1:0]  inst;
  riscv_isa_pkg::opcode_e            opcode;
  logic [2:0]                        funct3;
  logic                              alt;  // funct7 bit 5, sub / sra
  logic [riscv_pipe_pkg::XLEN-1:0]   imm_i, imm_u, imm_b, imm;
  logic                              we, use_imm;
  riscv_isa_pkg::alu_op_e            alu_op;
  riscv_isa_pkg::br_cond_e           br_cond;

  // an empty slot decodes as a nop so no x reaches the decoder
  assign inst   = i_fd_valid ? i_fd_inst : riscv_pipe_pkg::NOP_INST;
  assign opcode = riscv_isa_pkg::opcode_e'(inst[riscv_isa_pkg::OPCODE_LSB +: 7]);
  assign funct3 = inst[riscv_isa_pkg::FUNCT3_LSB +: 3];
  assign alt    = inst[riscv_isa_pkg::FUNCT7_LSB + 5];

  assign o_rs1_addr = inst[riscv_isa_pkg::RS1_LSB +: riscv_pipe_pkg::REG_AW];
  assign o_rs2_addr = inst[riscv_isa_pkg::RS2_LSB +: riscv_pipe_pkg::REG_AW];

  assign imm_i = {{(riscv_pipe_pkg::XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(riscv_pipe_pkg::XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_b = {{(riscv_pipe_pkg::XLEN-12){inst[31]}}, inst[7], inst[30:25],
                  inst[11:8], 1'b0};

  always_comb begin
    we      = 1'b0;
    use_imm = 1'b0;
    imm     = '0;
    br_cond = riscv_isa_pkg::BR_NONE;
    case (funct3)
      riscv_isa_pkg::F3_ADD_SUB: begin
        alu_op = (alt && opcode == riscv_isa_pkg::OPC_OP) ? riscv_isa_pkg::ALU_SUB
                                                          : riscv_isa_pkg::ALU_ADD;
      end
      riscv_isa_pkg::F3_SLL:     alu_op = riscv_isa_pkg::ALU_SLL;
      riscv_isa_pkg::F3_SLT:     alu_op = riscv_isa_pkg::ALU_SLT;
      riscv_isa_pkg::F3_SLTU:    alu_op = riscv_isa_pkg::ALU_SLTU;
      riscv_isa_pkg::F3_XOR:     alu_op = riscv_isa_pkg::ALU_XOR;
      riscv_isa_pkg::F3_SRL_SRA: alu_op = alt ? riscv_isa_pkg::ALU_SRA : riscv_isa_pkg::ALU_SRL;
      riscv_isa_pkg::F3_OR:      alu_op = riscv_isa_pkg::ALU_OR;
      default:                   alu_op = riscv_isa_pkg::ALU_AND;
    endcase
    case (opcode)
      riscv_isa_pkg::OPC_OP: we = 1'b1;
      riscv_isa_pkg::OPC_OP_IMM: begin
        we      = 1'b1;
        use_imm = 1'b1;
        imm     = imm_i;  // shamt sits in the low bits
      end
      riscv_isa_pkg::OPC_LUI: begin
        we      = 1'b1;
        use_imm = 1'b1;
        imm     = imm_u;
        alu_op  = riscv_isa_pkg::ALU_PASS_B;
      end
      riscv_isa_pkg::OPC_BRANCH: begin
        imm = imm_b;
        case (funct3)
          riscv_isa_pkg::F3_BEQ: br_cond = riscv_isa_pkg::BR_EQ;
          riscv_isa_pkg::F3_BNE: br_cond = riscv_isa_pkg::BR_NE;
          riscv_isa_pkg::F3_BLT: br_cond = riscv_isa_pkg::BR_LT;
          riscv_isa_pkg::F3_BGE: br_cond = riscv_isa_pkg::BR_GE;
          default:               br_cond = riscv_isa_pkg::BR_NONE;
        endcase
      end
      default: ;  // unknown opcode retires without a write
    endcase
  end

  always_ff @(posedge i_riscv_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_de_valid <= 1'b0;
    end else begin
      o_de_valid <= i_fd_valid & ~i_flush;
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    o_de_pc       <= i_fd_pc;
    o_de_rs1_addr <= o_rs1_addr;
    o_de_rs2_addr <= o_rs2_addr;
    o_de_rs1_data <= i_rs1_data;
    o_de_rs2_data <= i_rs2_data;
    o_de_imm      <= imm;
    o_de_rd       <= inst[riscv_isa_pkg::RD_LSB +: riscv_pipe_pkg::REG_AW];
    o_de_we       <= we;
    o_de_alu_op   <= alu_op;
    o_de_br_cond  <= br_cond;
    o_de_use_imm  <= use_imm;
  end

endmodule

// ==== rtl/riscv_regfile.sv ====
`timescale 1ns/1ps

module riscv_regfile (
  input  logic                              i_riscv_clk,
  input  logic                              i_rst_n,
  input  logic [riscv_pipe_pkg::REG_AW-1:0] i_rs1_addr,
  input  logic [riscv_pipe_pkg::REG_AW-1:0] i_rs2_addr,
  input  logic                              i_we,
  input  logic [riscv_pipe_pkg::REG_AW-1:0] i_rd_addr,
  input  logic [riscv_pipe_pkg::XLEN-1:0]   i_rd_data,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_rs1_data,
  output logic [riscv_pipe_pkg::XLEN-1:0]   o_rs2_data
);

  logic [riscv_pipe_pkg::XLEN-1:0] regs [riscv_pipe_pkg::NREGS];

  always_ff @(posedge i_riscv_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < riscv_pipe_pkg::NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd_addr != '0)) begin  // x0 never written
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                      (i_we && (i_rs1_addr == i_rd_addr)) ? i_rd_data : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                      (i_we && (i_rs2_addr == i_rd_addr)) ? i_rd_data : regs[i_rs2_addr];

endmodule

// ==== rtl/riscv_fstage.sv ====
`timescale 1ns/1ps

module riscv_fstage (
  input  logic                             i_riscv_clk,
  input  logic                             i_rst_n,
  input  logic [riscv_isa_pkg::INST_W-1:0] i_inst,
  input  logic                             i_inst_valid,
  input  logic                             i_flush,      // taken branch in execute
  input  logic [riscv_pipe_pkg::XLEN-1:0]  i_br_target,
  output logic [riscv_pipe_pkg::XLEN-1:0]  o_pc,
  output logic                             o_fd_valid,
  output logic [riscv_pipe_pkg::XLEN-1:0]  o_fd_pc,
  output logic [riscv_isa_pkg::INST_W-1:0] o_fd_inst
);

  logic [riscv_pipe_pkg::XLEN-1:0] pc_q;
  logic [riscv_pipe_pkg::XLEN-1:0] pc_next;
  logic                            take;  // word accepted this cycle

  assign take = i_inst_valid & ~i_flush;
  assign o_pc = pc_q;

  // redirect wins over a waiting pc
  always_comb begin
    if (i_flush) begin
      pc_next = i_br_target;
    end else if (i_inst_valid) begin
      pc_next = pc_q + 64'd4;
    end else begin
      pc_next = pc_q;
    end
  end

  always_ff @(posedge i_riscv_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q       <= riscv_pipe_pkg::RESET_PC;
      o_fd_valid <= 1'b0;
    end else begin
      pc_q       <= pc_next;
      o_fd_valid <= take;  // wrong-path word dropped on flush
    end
  end

  always_ff @(posedge i_riscv_clk) begin
    o_fd_pc   <= pc_q;
    o_fd_inst <= take ? i_inst : riscv_pipe_pkg::NOP_INST;  // bubbles carry a nop
  end

endmodule

// ==== rtl/riscv_pipe_pkg.sv ====
package riscv_pipe_pkg;

  localparam int XLEN   = 64;
  localparam int REG_AW = 5;
  localparam int NREGS  = 32;

  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

  // addi x0,x0,0
  localparam logic [31:0] NOP_INST = 32'h0000_0013;

  // operand source in execute
  typedef enum logic {
    FWD_NONE,  // value read in decode
    FWD_WB     // result held in execute/writeback
  } fwd_sel_e;

endpackage

// ==== rtl/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

  localparam int INST_W = 32;

  // field positions inside the instruction word
  localparam int OPCODE_LSB = 0;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B  // pass_b for lui
  } alu_op_e;

  typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE} br_cond_e;

  // funct3 for op / op_imm
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branch
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;

endpackage
